// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vrv_pipe_tb: rv_pipe_top.f logic/*.sv dv/*.sv
	verilator --binary --timing --assert -f rv_pipe_top.f --top-module rv_pipe_tb

run: obj_dir/Vrv_pipe_tb
	@out="$$(./obj_dir/Vrv_pipe_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing -f rv_pipe_top.f --top-module rv_pipe_tb

clean:
	rm -rf obj_dir

// File: dv/rv_pipe_tb.sv
`default_nettype none

module rv_pipe_tb
  import pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int IMEM_WORDS = 64;
  localparam int AW = $clog2(IMEM_WORDS);
  localparam int N_TESTS = 9;
  localparam int RUN_LIMIT = 40;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic          clk;
  logic          rst;
  logic          prog_we;
  logic [AW-1:0] prog_addr;
  logic [31:0]   prog_data;
  logic          halt;
  logic [31:0]   trace_pc;
  logic [31:0]   trace_insn;
  cycle_status_e trace_status;
  logic          trace_rd_we;
  logic [4:0]    trace_rd;
  logic [31:0]   trace_rd_data;

  // program words and expected write values in order for each test, and
  // meta columns of last rd, write count and squashed slots
  logic [31:0] prog [N_TESTS][8];
  logic [31:0] wr_val [N_TESTS][8];
  int          meta [N_TESTS][3];
  int          errors;
  int          timeouts;

  rv_pipe_top #(
    .IMEM_WORDS (IMEM_WORDS),
    .RESET_PC   (32'h0)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .prog_we       (prog_we),
    .prog_addr     (prog_addr),
    .prog_data     (prog_data),
    .halt          (halt),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_rd_we   (trace_rd_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [2:0] f3, input int rd, input int rs1,
                                         input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_word(input logic [6:0] op, input int rd, input int imm);
    return {20'(imm), 5'(rd), op};
  endfunction

  task automatic build_table();
    // immediate alu ops on a negative source
    prog[0] = '{i_word(3'b000, 1, 0, -5), i_word(3'b010, 2, 1, 0), i_word(3'b011, 3, 1, 5),
                i_word(3'b100, 4, 1, 'h0f0), i_word(3'b110, 5, 0, 'h555),
                i_word(3'b111, 6, 1, 'h07f), ECALL, ECALL};
    wr_val[0] = '{32'hffff_fffb, 32'h1, 32'h0, 32'hffff_ff0b, 32'h555, 32'h7b, 32'h0, 32'h0};
    meta[0] = '{6, 6, 0};
    // logical and arithmetic immediate shifts
    prog[1] = '{i_word(3'b000, 1, 0, -16), i_word(3'b001, 2, 1, 4), i_word(3'b101, 3, 1, 28),
                i_word(3'b101, 4, 1, 'h402), i_word(3'b101, 5, 2, 'h408),
                i_word(3'b101, 6, 2, 8), ECALL, ECALL};
    wr_val[1] = '{32'hffff_fff0, 32'hffff_ff00, 32'hf, 32'hffff_fffc, 32'hffff_ffff,
                  32'h00ff_ffff, 32'h0, 32'h0};
    meta[1] = '{6, 6, 0};
    prog[2] = '{i_word(3'b000, 1, 0, 100), i_word(3'b000, 2, 0, -3),
                r_word(7'h20, 3'b000, 3, 1, 2), r_word(7'h00, 3'b010, 4, 2, 1),
                r_word(7'h00, 3'b011, 5, 2, 1), r_word(7'h00, 3'b100, 6, 1, 2),
                r_word(7'h00, 3'b000, 7, 3, 4), ECALL};
    wr_val[2] = '{32'h64, 32'hffff_fffd, 32'h67, 32'h1, 32'h0, 32'hffff_ff99, 32'h68, 32'h0};
    meta[2] = '{7, 7, 0};
    prog[3] = '{u_word(7'b0110111, 1, 'h80000), i_word(3'b000, 2, 0, 4),
                r_word(7'h20, 3'b101, 3, 1, 2), r_word(7'h00, 3'b101, 4, 1, 2),
                r_word(7'h00, 3'b001, 5, 2, 2), r_word(7'h00, 3'b110, 6, 3, 5),
                r_word(7'h00, 3'b111, 7, 6, 4), ECALL};
    wr_val[3] = '{32'h8000_0000, 32'h4, 32'hf800_0000, 32'h0800_0000, 32'h40,
                  32'hf800_0040, 32'h0800_0000, 32'h0};
    meta[3] = '{7, 7, 0};
    // chained sources at distance 1, 2 and 3
    prog[4] = '{i_word(3'b000, 1, 0, 1), r_word(7'h00, 3'b000, 2, 1, 1),
                r_word(7'h00, 3'b000, 3, 2, 1), r_word(7'h00, 3'b000, 4, 3, 1),
                r_word(7'h00, 3'b000, 5, 4, 2), r_word(7'h00, 3'b000, 6, 5, 3),
                r_word(7'h20, 3'b000, 7, 6, 1), ECALL};
    wr_val[4] = '{32'h1, 32'h2, 32'h3, 32'h4, 32'h6, 32'h9, 32'h8, 32'h0};
    meta[4] = '{7, 7, 0};
    // auipc results depend on the word position at pc 4 and pc 8
    prog[5] = '{u_word(7'b0110111, 1, 'h12345), u_word(7'b0010111, 2, 'h1),
                u_word(7'b0010111, 3, 'hfffff), i_word(3'b000, 4, 1, 'h678),
                r_word(7'h00, 3'b000, 5, 4, 2), r_word(7'h00, 3'b000, 6, 5, 3), ECALL, ECALL};
    wr_val[5] = '{32'h1234_5000, 32'h0000_1004, 32'hffff_f008, 32'h1234_5678,
                  32'h1234_667c, 32'h1234_5684, 32'h0, 32'h0};
    meta[5] = '{6, 6, 0};
    // bne falls through and beq jumps over two words
    prog[6] = '{i_word(3'b000, 1, 0, 7), i_word(3'b000, 2, 0, 7), b_word(3'b001, 1, 2, 8),
                b_word(3'b000, 1, 2, 12), i_word(3'b000, 3, 0, 1), i_word(3'b000, 3, 0, 2),
                i_word(3'b000, 3, 1, 9), ECALL};
    wr_val[6] = '{32'h7, 32'h7, 32'h10, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    meta[6] = '{3, 3, 2};
    prog[7] = '{i_word(3'b000, 1, 0, -1), i_word(3'b000, 2, 0, 1), b_word(3'b101, 1, 2, 8),
                b_word(3'b100, 1, 2, 12), i_word(3'b000, 3, 0, 1), i_word(3'b000, 3, 0, 2),
                i_word(3'b100, 3, 1, 'h0aa), ECALL};
    wr_val[7] = '{32'hffff_ffff, 32'h1, 32'hffff_ff55, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    meta[7] = '{3, 3, 2};
    // bgeu target is the word fetched in the redirect cycle
    prog[8] = '{i_word(3'b000, 1, 0, -1), i_word(3'b000, 2, 0, 1), b_word(3'b110, 1, 2, 8),
                b_word(3'b111, 1, 2, 8), i_word(3'b000, 3, 0, 1), i_word(3'b000, 3, 2, 40),
                ECALL, ECALL};
    wr_val[8] = '{32'hffff_ffff, 32'h1, 32'h29, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    meta[8] = '{3, 3, 2};
  endtask

  task automatic report_mismatch(input int t, input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("[FAIL] %0t: test %0d %s, got %h expected %h", $time, t, what, got, exp);
  endtask

  // whole rom is written under reset with addi x0 words tagged by address past the program
  task automatic load_program(input int t);
    for (int a = 0; a < IMEM_WORDS; a++) begin
      @(posedge clk);
      rst       <= 1'b1;
      prog_we   <= 1'b1;
      prog_addr <= AW'(a);
      prog_data <= (a < 8) ? prog[t][a] : i_word(3'b000, 0, 0, a);
    end
    @(posedge clk);
    prog_we <= 1'b0;
    rst     <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int         c;
    int         nwr;
    int         nsq;
    int         prev_pc;
    int         ecall_pc;
    logic [4:0] last_rd;
    logic       done;
    logic       exp_halt;
    load_program(t);
    c = 0;
    nwr = 0;
    nsq = 0;
    prev_pc = -1;
    last_rd = '0;
    done = 1'b0;
    // halt belongs to the first ecall word of the program
    ecall_pc = -1;
    for (int i = 7; i >= 0; i--) begin
      if (prog[t][i] == ECALL)
        ecall_pc = 4 * i;
    end
    while (!done && c < RUN_LIMIT) begin
      @(negedge clk);
      if (c < 4) begin
        if (trace_status != CYCLE_RESET)
          report_mismatch(t, "status before first insn", 32'(trace_status), 32'(CYCLE_RESET));
        if (trace_rd_we || halt)
          report_mismatch(t, "rd_we and halt before first insn", {30'd0, trace_rd_we, halt}, 0);
      end else if (trace_status == CYCLE_TAKEN_BRANCH) begin
        nsq++;
        if (trace_pc != 0)
          report_mismatch(t, "squashed slot pc", trace_pc, 0);
        if (trace_insn != 0)
          report_mismatch(t, "squashed slot insn", trace_insn, 0);
      end else if (trace_status == CYCLE_NO_STALL) begin
        if (int'(trace_pc) <= prev_pc)
          report_mismatch(t, "trace pc out of program order", trace_pc, prev_pc + 4);
        else if (trace_insn != prog[t][trace_pc[4:2]])
          report_mismatch(t, "trace insn at its pc", trace_insn, prog[t][trace_pc[4:2]]);
        prev_pc = int'(trace_pc);
      end else begin
        report_mismatch(t, "trace status", 32'(trace_status), 32'(CYCLE_NO_STALL));
      end
      // fixed four-cycle latency for the word at pc 0
      if (c == 4 && (trace_status != CYCLE_NO_STALL || trace_pc != 0))
        report_mismatch(t, "first retired pc", trace_pc, 0);
      if (trace_rd_we) begin
        if (nwr < 8 && trace_rd_data != wr_val[t][nwr])
          report_mismatch(t, $sformatf("write %0d value", nwr), trace_rd_data, wr_val[t][nwr]);
        last_rd = trace_rd;
        nwr++;
      end
      exp_halt = trace_status == CYCLE_NO_STALL && int'(trace_pc) == ecall_pc;
      if (halt != exp_halt)
        report_mismatch(t, "halt against the ecall slot", {31'd0, halt}, {31'd0, exp_halt});
      if (halt) begin
        done = 1'b1;
        if (trace_insn != ECALL)
          report_mismatch(t, "insn at halt", trace_insn, ECALL);
      end
      c++;
    end
    if (!done) begin
      timeouts++;
      $display("test %0d timed out: halt never rose within %0d cycles", t, RUN_LIMIT);
    end else begin
      if (32'(last_rd) != meta[t][0])
        report_mismatch(t, "last write rd", 32'(last_rd), meta[t][0]);
      if (nwr != meta[t][1])
        report_mismatch(t, "write count", nwr, meta[t][1]);
      if (nsq != meta[t][2])
        report_mismatch(t, "squashed slot count", nsq, meta[t][2]);
    end
  endtask

  initial begin
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors    = 0;
    timeouts  = 0;
    build_table();
    repeat (2) @(posedge clk);
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d value errors, %0d timeouts", N_TESTS, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`default_nettype none

module decode_unit
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  wire                clk,
  input  wire                rst,
  input  wire word_t         d_pc,
  input  wire word_t         d_insn,
  input  wire cycle_status_e d_status,
  input  wire                redirect,
  input  wire word_t         rs1_data,
  input  wire word_t         rs2_data,
  input  wire reg_addr_t     wb_rd,
  input  wire word_t         wb_data,
  output reg_addr_t          rs1,
  output reg_addr_t          rs2,
  output word_t              x_pc,
  output word_t              x_insn,
  output cycle_status_e      x_status,
  output word_t              x_rs1_data,
  output word_t              x_rs2_data
);

  rv_insn_u d_word;

  // source fields sit in the same place in every format that has them
  assign d_word = d_insn;
  assign rs1    = d_word.r.rs1;
  assign rs2    = d_word.r.rs2;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= NOP_WORD;
      x_status <= CYCLE_RESET;
    end else if (redirect) begin
      x_pc     <= '0;
      x_insn   <= NOP_WORD;
      x_status <= CYCLE_TAKEN_BRANCH;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
    end
  end

  // writeback result is not in the register file until the end of this cycle
  always_ff @(posedge clk) begin
    x_rs1_data <= (wb_rd != '0 && wb_rd == rs1) ? wb_data : rs1_data;
    x_rs2_data <= (wb_rd != '0 && wb_rd == rs2) ? wb_data : rs2_data;
  end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`default_nettype none

module execute_unit
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  wire                clk,
  input  wire                rst,
  input  wire word_t         x_pc,
  input  wire word_t         x_insn,
  input  wire cycle_status_e x_status,
  input  wire word_t         x_rs1_data,
  input  wire word_t         x_rs2_data,
  input  wire reg_addr_t     mem_rd,
  input  wire word_t         mem_data,
  input  wire reg_addr_t     wb_rd,
  input  wire word_t         wb_data,
  output logic               redirect,
  output word_t              target,
  output word_t              m_pc,
  output word_t              m_insn,
  output cycle_status_e      m_status,
  output word_t              m_result
);

  rv_insn_u insn;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_b;
  word_t    imm_i;
  word_t    imm_b;
  word_t    imm_u;
  word_t    sra_out;
  word_t    alu_out;
  word_t    result;
  logic     is_reg_reg;
  logic     use_alt;
  logic     taken;

  assign insn = x_insn;

  // memory stage holds the younger value and wins over writeback
  assign op_a = (mem_rd != '0 && mem_rd == insn.r.rs1) ? mem_data :
                (wb_rd != '0 && wb_rd == insn.r.rs1) ? wb_data : x_rs1_data;
  assign op_b = (mem_rd != '0 && mem_rd == insn.r.rs2) ? mem_data :
                (wb_rd != '0 && wb_rd == insn.r.rs2) ? wb_data : x_rs2_data;

  assign imm_i = {{20{insn.i.imm12[11]}}, insn.i.imm12};
  assign imm_b = {{20{insn.b.imm12}}, insn.b.imm11, insn.b.imm10_5, insn.b.imm4_1, 1'b0};
  assign imm_u = {insn.u.imm20, 12'd0};

  assign is_reg_reg = insn.r.opcode == OP_REG_REG;
  assign alu_b      = is_reg_reg ? op_b : imm_i;
  // sub only exists in register form, sra in both
  assign use_alt    = insn.r.funct7 == FUNCT7_ALT;
  assign sra_out    = $signed(op_a) >>> alu_b[4:0];

  always_comb begin
    case (insn.r.funct3)
      F3_ADD_SUB: alu_out = (is_reg_reg && use_alt) ? op_a - alu_b : op_a + alu_b;
      F3_SLL:     alu_out = op_a << alu_b[4:0];
      F3_SLT:     alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
      F3_SLTU:    alu_out = {31'd0, op_a < alu_b};
      F3_XOR:     alu_out = op_a ^ alu_b;
      F3_SRL_SRA: alu_out = use_alt ? sra_out : op_a >> alu_b[4:0];
      F3_OR:      alu_out = op_a | alu_b;
      F3_AND:     alu_out = op_a & alu_b;
    endcase
  end

  always_comb begin
    case (insn.u.opcode)
      OP_LUI:   result = imm_u;
      OP_AUIPC: result = x_pc + imm_u;
      default:  result = alu_out;
    endcase
  end

  always_comb begin
    case (insn.b.funct3)
      F3_BEQ:  taken = op_a == op_b;
      F3_BNE:  taken = op_a != op_b;
      F3_BLT:  taken = $signed(op_a) < $signed(op_b);
      F3_BGE:  taken = $signed(op_a) >= $signed(op_b);
      F3_BLTU: taken = op_a < op_b;
      F3_BGEU: taken = op_a >= op_b;
      default: taken = 1'b0;
    endcase
  end

  // every taken branch redirects and squashes fetch and decode
  assign redirect = insn.b.opcode == OP_BRANCH && taken;
  assign target   = x_pc + imm_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= NOP_WORD;
      m_status <= CYCLE_RESET;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
    end
  end

  always_ff @(posedge clk) begin
    m_result <= result;
  end

  // a reset bubble reaching execute must never steer fetch
  assert property (@(posedge clk) disable iff (rst) x_status == CYCLE_RESET |-> !redirect)
    else $error("execute_unit: redirect from a reset slot");

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`default_nettype none

module fetch_unit
  import rv_isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  wire           clk,
  input  wire           rst,
  input  wire word_t    insn,
  input  wire           redirect,
  input  wire word_t    target,
  output word_t         pc,
  output word_t         d_pc,
  output word_t         d_insn,
  output cycle_status_e d_status
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= RESET_PC;
      d_pc     <= '0;
      d_insn   <= NOP_WORD;
      d_status <= CYCLE_RESET;
    end else if (redirect) begin
      // taken branch in execute kills the word fetched this cycle
      pc       <= target;
      d_pc     <= '0;
      d_insn   <= NOP_WORD;
      d_status <= CYCLE_TAKEN_BRANCH;
    end else begin
      pc       <= pc + word_t'(4);
      d_pc     <= pc;
      d_insn   <= insn;
      d_status <= CYCLE_NO_STALL;
    end
  end

endmodule

`default_nettype wire

// File: logic/insn_rom.sv
`default_nettype none

module insn_rom
  import rv_isa_pkg::*;
#(
  parameter int IMEM_WORDS = 64
) (
  input  wire                          clk,
  input  wire                          prog_we,
  input  wire [$clog2(IMEM_WORDS)-1:0] prog_addr,
  input  wire word_t                   prog_data,
  input  wire word_t                   pc,
  output word_t                        insn
);

  localparam int AW = $clog2(IMEM_WORDS);

  word_t mem [IMEM_WORDS];

  // program load port, only used while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // byte pc to word index
  assign insn = mem[pc[AW+1:2]];

  // sequential fetch and every branch target must land on a word boundary
  assert property (@(posedge clk) !$isunknown(pc) |-> pc[1:0] == 2'b00)
    else $error("insn_rom: misaligned pc %h", pc);

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // what occupies a pipeline slot, carried down to the writeback trace
  typedef enum logic [1:0] {
    CYCLE_RESET        = 2'd0,
    CYCLE_NO_STALL     = 2'd1,
    CYCLE_TAKEN_BRANCH = 2'd2
  } cycle_status_e;

  // all-zero word fills squashed slots and decodes as no operation
  localparam logic [31:0] NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

module reg_file
  import rv_isa_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            we,
  input  wire reg_addr_t rd,
  input  wire word_t     rd_data,
  input  wire reg_addr_t rs1,
  input  wire reg_addr_t rs2,
  output word_t          rs1_data,
  output word_t          rs2_data
);

  word_t regs [32];

  // x0 always reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/retire_unit.sv
`default_nettype none

module retire_unit
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  wire                clk,
  input  wire                rst,
  input  wire word_t         m_pc,
  input  wire word_t         m_insn,
  input  wire cycle_status_e m_status,
  input  wire word_t         m_result,
  output reg_addr_t          mem_rd,
  output word_t              mem_data,
  output logic               wb_we,
  output reg_addr_t          wb_rd,
  output word_t              wb_data,
  output logic               halt,
  output word_t              trace_pc,
  output word_t              trace_insn,
  output cycle_status_e      trace_status,
  output logic               trace_rd_we,
  output reg_addr_t          trace_rd,
  output word_t              trace_rd_data
);

  rv_insn_u  m_word;
  rv_insn_u  w_insn;
  reg_addr_t w_rd;
  logic      m_writes;

  assign m_word = m_insn;

  // only alu, lui and auipc results go to the register file
  always_comb begin
    case (m_word.r.opcode)
      OP_LUI, OP_AUIPC, OP_REG_IMM, OP_REG_REG: m_writes = 1'b1;
      default:                                  m_writes = 1'b0;
    endcase
  end

  // no data memory here, so the memory stage just offers its result for forwarding
  assign mem_rd   = m_writes ? m_word.r.rd : '0;
  assign mem_data = m_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      trace_pc     <= '0;
      w_insn       <= NOP_WORD;
      trace_status <= CYCLE_RESET;
      wb_we        <= 1'b0;
    end else begin
      trace_pc     <= m_pc;
      w_insn       <= m_insn;
      trace_status <= m_status;
      wb_we        <= m_writes;
    end
  end

  always_ff @(posedge clk) begin
    w_rd    <= m_word.r.rd;
    wb_data <= m_result;
  end

  assign wb_rd = wb_we ? w_rd : '0;

  // ecall is the environment opcode with every other field zero
  assign halt = w_insn.i.opcode == OP_ENVIRON && w_insn[31:7] == 25'd0;

  assign trace_insn    = w_insn;
  assign trace_rd_we   = wb_we;
  assign trace_rd      = wb_rd;
  assign trace_rd_data = wb_data;

  assert property (@(posedge clk) disable iff (rst) halt |-> !wb_we)
    else $error("retire_unit: register write on the halting slot");

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [XLEN-1:0] word_t;

  // major opcodes handled by this core
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_REG_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG_REG = 7'b0110011;
  localparam logic [6:0] OP_ENVIRON = 7'b1110011;

  // alu funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // selects sub and the arithmetic right shift
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch offset bits are scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } rv_insn_u;

endpackage

`default_nettype wire

// File: logic/rv_pipe_top.sv
`default_nettype none

module rv_pipe_top
  import rv_isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int    IMEM_WORDS = 64,
  parameter word_t RESET_PC   = '0
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          prog_we,
  input  wire [$clog2(IMEM_WORDS)-1:0] prog_addr,
  input  wire word_t                   prog_data,
  output logic                         halt,
  output word_t                        trace_pc,
  output word_t                        trace_insn,
  output cycle_status_e                trace_status,
  output logic                         trace_rd_we,
  output reg_addr_t                    trace_rd,
  output word_t                        trace_rd_data
);

  // fetch and decode side
  word_t         pc, insn, target, d_pc, d_insn;
  word_t         rs1_data, rs2_data;
  reg_addr_t     rs1, rs2;
  cycle_status_e d_status;
  logic          redirect;

  // execute onwards
  word_t         x_pc, x_insn, x_rs1_data, x_rs2_data;
  word_t         m_pc, m_insn, m_result, mem_data, wb_data;
  reg_addr_t     mem_rd, wb_rd;
  cycle_status_e x_status, m_status;
  logic          wb_we;

  insn_rom #(.IMEM_WORDS(IMEM_WORDS)) u_rom (.*);

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (.*);

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_we),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  decode_unit u_decode (.*);

  execute_unit u_execute (.*);

  retire_unit u_retire (.*);

endmodule

`default_nettype wire

// File: rv_pipe_top.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/insn_rom.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/retire_unit.sv
logic/rv_pipe_top.sv
dv/rv_pipe_tb.sv
